// ==== common/dma_cfg.svh ====
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Configuration register map
`define DMA_REG_EN  32'h10020100
`define DMA_REG_SRC 32'h10020200
`define DMA_REG_DST 32'h10020300
`define DMA_REG_LEN 32'h10020400

// Longest burst in words
`define DMA_MAX_BURST 4

// Bursts must stay inside one page
`define DMA_PAGE_BYTES 4096

// Bytes per memory word
`define DMA_WORD_BYTES 4

// Words held by the burst buffer
`define DMA_BUF_DEPTH 4

`endif

// ==== common/dma_pkg.sv ====
package dma_pkg;

	// Byte address on both the configuration and the memory side
	typedef logic [31:0] addr_t;

	// One memory word
	typedef logic [31:0] data_t;

	// Beat index inside a burst, wide enough for the lookahead index
	typedef logic [2:0] beat_t;

	// Burst length minus one, as seen on mem_burst_len
	typedef logic [3:0] burst_len_t;

	// Engine states, shared with the checker model
	typedef enum logic [1:0] {
		IDLE  = 2'd0, // Waiting for enable
		READ  = 2'd1, // Read burst into the buffer
		WRITE = 2'd2, // Write burst out of the buffer
		DONE  = 2'd3  // Copy complete, irq high
	} dma_state_e;

endpackage

// ==== dma/dma_regs.sv ====
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_regs (
	input  logic            clk,
	input  logic            rst,
	input  logic            cfg_en,
	input  dma_pkg::addr_t  cfg_addr,
	input  dma_pkg::data_t  cfg_data,
	input  logic            busy,
	output logic            enable,
	output dma_pkg::addr_t  src_addr,
	output dma_pkg::addr_t  dst_addr,
	output dma_pkg::data_t  len_words
);
	import dma_pkg::*;

	logic wr_ok;

	// Registers are frozen while a copy runs
	assign wr_ok = cfg_en && !busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			enable    <= 1'b0;
			src_addr  <= '0;
			dst_addr  <= '0;
			len_words <= '0;
		end else if (wr_ok) begin
			case (cfg_addr)
				`DMA_REG_EN: begin
					enable <= cfg_data[0]; // Only bit 0 is used
				end
				`DMA_REG_SRC: begin
					src_addr <= addr_t'(cfg_data);
				end
				`DMA_REG_DST: begin
					dst_addr <= addr_t'(cfg_data);
				end
				`DMA_REG_LEN: begin
					len_words <= cfg_data; // Kept in words, not bytes
				end
				default: begin
					// Unknown address, write dropped
				end
			endcase
		end
	end

endmodule

// ==== dma/dma_burst_planner.sv ====
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_burst_planner (
	input  logic                 clk,
	input  logic                 rst,
	input  dma_pkg::addr_t       rd_addr,
	input  dma_pkg::addr_t       wr_addr,
	input  dma_pkg::data_t       remaining,
	output dma_pkg::burst_len_t  burst_len
);
	import dma_pkg::*;

	localparam int PAGE_BITS  = $clog2(`DMA_PAGE_BYTES);
	localparam int WORD_BITS  = $clog2(`DMA_WORD_BYTES);
	localparam int PAGE_WORDS = `DMA_PAGE_BYTES / `DMA_WORD_BYTES;

	data_t rd_left;
	data_t wr_left;
	data_t limit;

	// Words left before each address reaches its page end
	assign rd_left = data_t'(PAGE_WORDS) - data_t'(rd_addr[PAGE_BITS-1:WORD_BITS]);
	assign wr_left = data_t'(PAGE_WORDS) - data_t'(wr_addr[PAGE_BITS-1:WORD_BITS]);

	always_comb begin
		limit = data_t'(`DMA_MAX_BURST);
		if (remaining < limit) begin
			limit = remaining;
		end
		if (rd_left < limit) begin
			limit = rd_left; // Source page end is closer
		end
		if (wr_left < limit) begin
			limit = wr_left; // Destination page end is closer
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			burst_len <= '0;
		end else if (limit == '0) begin
			burst_len <= '0; // Nothing left, avoid wrapping to 15
		end else begin
			burst_len <= burst_len_t'(limit - 32'd1);
		end
	end

endmodule

// ==== dma/dma_burst_buffer.sv ====
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_burst_buffer (
	input  logic            clk,
	input  logic            rst,
	input  logic            wr_en,
	input  dma_pkg::beat_t  wr_idx,
	input  dma_pkg::data_t  wr_data,
	input  dma_pkg::beat_t  rd_idx,
	input  logic            advance,
	output dma_pkg::data_t  rd_data
);
	import dma_pkg::*;

	localparam int DEPTH = `DMA_BUF_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	data_t              mem [DEPTH];
	logic [DEPTH-1:0]   filled;
	beat_t              nxt_idx;
	logic [IDX_W-1:0]   sel;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_idx[IDX_W-1:0]] <= wr_data;
		end
	end

	// Tracks entries written since reset so unwritten words read as zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			filled <= '0;
		end else if (wr_en) begin
			filled[wr_idx[IDX_W-1:0]] <= 1'b1;
		end
	end

	// Lookahead so the next beat is on the bus right after an accept
	assign nxt_idx = rd_idx + beat_t'(1);
	assign sel     = advance ? nxt_idx[IDX_W-1:0] : rd_idx[IDX_W-1:0];
	assign rd_data = filled[sel] ? mem[sel] : '0;

endmodule

// ==== dma/dma_engine.sv ====
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_engine (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enable,
	input  dma_pkg::addr_t       src_addr,
	input  dma_pkg::addr_t       dst_addr,
	input  dma_pkg::data_t       len_words,
	input  dma_pkg::burst_len_t  burst_len,
	input  dma_pkg::data_t       buf_data,
	input  dma_pkg::data_t       mem_rdata,
	input  logic                 mem_rvalid,
	input  logic                 mem_wvalid,
	output logic                 busy,
	output dma_pkg::addr_t       rd_addr,
	output dma_pkg::addr_t       wr_addr,
	output dma_pkg::data_t       remaining,
	output logic                 buf_wr_en,
	output dma_pkg::beat_t       buf_wr_idx,
	output dma_pkg::data_t       buf_wr_data,
	output dma_pkg::beat_t       buf_rd_idx,
	output logic                 buf_advance,
	output dma_pkg::addr_t       mem_addr,
	output logic [3:0]           mem_bweb,
	output dma_pkg::data_t       mem_wdata,
	output dma_pkg::burst_len_t  mem_burst_len,
	output logic                 mem_ceb,
	output logic                 mem_web,
	output logic                 irq
);
	import dma_pkg::*;

	dma_state_e state;
	dma_state_e state_nxt;
	beat_t      cnt;
	logic       plan_wait; // Planner still settling on new addresses
	logic       last_beat;
	logic       rd_beat;
	logic       wr_beat;
	data_t      burst_words;
	addr_t      burst_bytes;

	assign last_beat   = ({1'b0, cnt} == burst_len);
	assign rd_beat     = (state == READ) && !plan_wait && mem_rvalid;
	assign wr_beat     = (state == WRITE) && mem_wvalid;
	assign burst_words = data_t'(burst_len) + 32'd1;
	assign burst_bytes = addr_t'(burst_words * `DMA_WORD_BYTES);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:  if (enable) state_nxt = READ;
			READ:  if (rd_beat && last_beat) state_nxt = WRITE;
			WRITE: begin
				if (wr_beat && last_beat) begin
					state_nxt = (remaining == burst_words) ? DONE : READ;
				end
			end
			DONE:  if (!enable) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= IDLE;
			cnt       <= '0;
			plan_wait <= 1'b0;
			rd_addr   <= '0;
			wr_addr   <= '0;
			remaining <= '0;
		end else begin
			state <= state_nxt;
			case (state)
				IDLE: begin
					rd_addr   <= src_addr; // Track registers so the planner is settled
					wr_addr   <= dst_addr;
					remaining <= len_words;
					cnt       <= '0;
					plan_wait <= 1'b0;
				end
				READ: begin
					plan_wait <= 1'b0;
					if (rd_beat) begin
						cnt <= last_beat ? beat_t'(0) : cnt + beat_t'(1);
					end
				end
				WRITE: begin
					if (wr_beat) begin
						cnt <= last_beat ? beat_t'(0) : cnt + beat_t'(1);
						if (last_beat) begin
							rd_addr   <= rd_addr + burst_bytes;
							wr_addr   <= wr_addr + burst_bytes;
							remaining <= remaining - burst_words;
							plan_wait <= 1'b1; // Next read burst waits one cycle
						end
					end
				end
				default: begin
					cnt <= '0;
				end
			endcase
		end
	end

	assign busy = (state == READ) || (state == WRITE);

	// Burst buffer side
	assign buf_wr_en   = rd_beat;
	assign buf_wr_idx  = cnt;
	assign buf_wr_data = mem_rdata;
	assign buf_rd_idx  = cnt;
	assign buf_advance = wr_beat;

	// Memory port
	assign mem_ceb       = !(((state == READ) && !plan_wait) || (state == WRITE));
	assign mem_web       = (state != WRITE);
	assign mem_addr      = (state == WRITE || state == DONE) ? wr_addr : rd_addr;
	assign mem_bweb      = (state == WRITE) ? 4'h0 : 4'hf;
	assign mem_wdata     = buf_data;
	assign mem_burst_len = burst_len;
	assign irq           = (state == DONE); // Held until enable clears

endmodule

// ==== hdl/dma_top.sv ====
`timescale 1ns/1ps

module dma_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cfg_en,
	input  dma_pkg::addr_t       cfg_addr,
	input  dma_pkg::data_t       cfg_data,
	input  dma_pkg::data_t       mem_rdata,
	input  logic                 mem_rvalid,
	input  logic                 mem_wvalid,
	output dma_pkg::addr_t       mem_addr,
	output logic [3:0]           mem_bweb,
	output dma_pkg::data_t       mem_wdata,
	output dma_pkg::burst_len_t  mem_burst_len,
	output logic                 mem_ceb,
	output logic                 mem_web,
	output logic                 irq
);
	import dma_pkg::*;

	logic       enable;
	logic       busy;
	addr_t      src_addr;
	addr_t      dst_addr;
	data_t      len_words;
	addr_t      rd_addr;
	addr_t      wr_addr;
	data_t      remaining;
	burst_len_t burst_len;
	logic       buf_wr_en;
	beat_t      buf_wr_idx;
	data_t      buf_wr_data;
	beat_t      buf_rd_idx;
	logic       buf_advance;
	data_t      buf_data;

	dma_regs u_regs (
		.clk       (clk),
		.rst       (rst),
		.cfg_en    (cfg_en),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.busy      (busy),
		.enable    (enable),
		.src_addr  (src_addr),
		.dst_addr  (dst_addr),
		.len_words (len_words)
	);

	dma_burst_planner u_planner (
		.clk       (clk),
		.rst       (rst),
		.rd_addr   (rd_addr),
		.wr_addr   (wr_addr),
		.remaining (remaining),
		.burst_len (burst_len)
	);

	dma_burst_buffer u_buffer (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (buf_wr_en),
		.wr_idx  (buf_wr_idx),
		.wr_data (buf_wr_data),
		.rd_idx  (buf_rd_idx),
		.advance (buf_advance),
		.rd_data (buf_data)
	);

	dma_engine u_engine (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.src_addr      (src_addr),
		.dst_addr      (dst_addr),
		.len_words     (len_words),
		.burst_len     (burst_len),
		.buf_data      (buf_data),
		.mem_rdata     (mem_rdata),
		.mem_rvalid    (mem_rvalid),
		.mem_wvalid    (mem_wvalid),
		.busy          (busy),
		.rd_addr       (rd_addr),
		.wr_addr       (wr_addr),
		.remaining     (remaining),
		.buf_wr_en     (buf_wr_en),
		.buf_wr_idx    (buf_wr_idx),
		.buf_wr_data   (buf_wr_data),
		.buf_rd_idx    (buf_rd_idx),
		.buf_advance   (buf_advance),
		.mem_addr      (mem_addr),
		.mem_bweb      (mem_bweb),
		.mem_wdata     (mem_wdata),
		.mem_burst_len (mem_burst_len),
		.mem_ceb       (mem_ceb),
		.mem_web       (mem_web),
		.irq           (irq)
	);

endmodule

// ==== verification/dma_mem_model.sv ====
`timescale 1ns/1ps

module dma_mem_model (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 mem_ceb,
	input  logic                 mem_web,
	input  dma_pkg::addr_t       mem_addr,
	input  dma_pkg::burst_len_t  mem_burst_len,
	input  dma_pkg::data_t       mem_wdata,
	output dma_pkg::data_t       mem_rdata,
	output logic                 mem_rvalid,
	output logic                 mem_wvalid
);
	import dma_pkg::*;

	localparam data_t SRC_KEY = 32'h5a3c96e1; // Source word is address XOR this

	data_t  store [addr_t]; // Written words by byte address
	integer seed = 32'hcc852b32;
	logic   active;
	logic   is_wr;
	addr_t  base;
	int     n;
	int     beat;
	int     gap;

	// Decides, at each edge, whether the coming cycle carries a valid beat
	task automatic drive_beat();
		addr_t a;
		a = base + addr_t'(4 * beat);
		if (gap > 0) begin
			gap = gap - 1;
			mem_rvalid <= 1'b0;
			mem_wvalid <= 1'b0;
		end else begin
			if (is_wr) begin
				store[a] = mem_wdata; // Word presented for the beat about to be accepted
				mem_wvalid <= 1'b1;
			end else begin
				mem_rdata  <= a ^ SRC_KEY;
				mem_rvalid <= 1'b1;
			end
			gap = int'($unsigned($random(seed)) % 4);
		end
	endtask

	// Word written at a byte address, removed once read back
	function automatic data_t take_word(addr_t a);
		data_t d;
		d = 'x;
		if (store.exists(a)) begin
			d = store[a];
			store.delete(a);
		end
		return d;
	endfunction

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			active     = 1'b0;
			mem_rvalid <= 1'b0;
			mem_wvalid <= 1'b0;
			mem_rdata  <= '0;
		end else if (active) begin
			if (mem_rvalid || mem_wvalid) begin
				beat = beat + 1;
			end
			if (beat == n) begin
				active = 1'b0; // Burst done, ceb is stale on this edge
				mem_rvalid <= 1'b0;
				mem_wvalid <= 1'b0;
			end else begin
				drive_beat();
			end
		end else if (!mem_ceb) begin
			active = 1'b1;
			is_wr  = !mem_web;
			base   = mem_addr;
			n      = int'(mem_burst_len) + 1;
			beat   = 0;
			gap    = int'($unsigned($random(seed)) % 4);
			drive_beat();
		end
	end

endmodule

// ==== verification/dma_checker.sv ====
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_checker (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 mem_ceb,
	input  logic                 mem_web,
	input  dma_pkg::addr_t       mem_addr,
	input  logic [3:0]           mem_bweb,
	input  dma_pkg::data_t       mem_wdata,
	input  dma_pkg::burst_len_t  mem_burst_len,
	input  logic                 mem_rvalid,
	input  logic                 mem_wvalid
);
	import dma_pkg::*;

	localparam data_t SRC_KEY = 32'h5a3c96e1;

	dma_state_e phase; // Expected direction of the next burst
	addr_t      exp_rd;
	addr_t      exp_wr;
	addr_t      test_src;
	addr_t      test_dst;
	addr_t      last_byte;
	data_t      prev_wdata; // Write data lives one cycle ahead of its valid
	logic       active = 1'b0;
	logic       in_burst = 1'b0;
	int         rem;
	int         n;
	int         beat;
	int         words;
	int         test_len;
	int         test_err;
	int         err_cnt = 0;
	int         pass_cnt = 0;
	int         fail_cnt = 0;

	function automatic int words_to_page_end(addr_t a);
		return (`DMA_PAGE_BYTES - int'(a[11:0])) / 4;
	endfunction

	function automatic int next_burst_words();
		int w;
		w = `DMA_MAX_BURST;
		if (rem < w) w = rem;
		if (words_to_page_end(exp_rd) < w) w = words_to_page_end(exp_rd);
		if (words_to_page_end(exp_wr) < w) w = words_to_page_end(exp_wr);
		return w;
	endfunction

	task automatic mismatch(string name, data_t got, data_t exp);
		$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
		test_err = test_err + 1;
		err_cnt  = err_cnt + 1;
	endtask

	task automatic start_test(addr_t src, addr_t dst, int len);
		exp_rd   = src;
		exp_wr   = dst;
		test_src = src;
		test_dst = dst;
		rem      = len;
		test_len = len;
		words    = 0;
		test_err = 0;
		phase    = READ;
		in_burst = 1'b0;
		active   = 1'b1;
	endtask

	// Destination word i must hold source word i
	task automatic check_word(int i, data_t got);
		addr_t a;
		data_t exp;
		a   = test_dst + addr_t'(4 * i);
		exp = (test_src + addr_t'(4 * i)) ^ SRC_KEY;
		if (got !== exp)
			mismatch($sformatf("store[0x%08h]", a), got, exp);
	endtask

	task automatic end_test(int idx);
		if (words != test_len) begin
			$display("Test %0d wrote %0d words instead of %0d", idx, words, test_len);
			test_err = test_err + 1;
			err_cnt  = err_cnt + 1;
		end
		active = 1'b0;
		if (test_err == 0) pass_cnt = pass_cnt + 1;
		else fail_cnt = fail_cnt + 1;
		$display("Test %0d: src 0x%08h len %0d words, %0d errors", idx,
			test_src, test_len, test_err);
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (in_burst) begin
				if ((phase == READ && mem_rvalid) || (phase == WRITE && mem_wvalid)) begin
					if (phase == WRITE) begin
						if (prev_wdata !== ((exp_rd + addr_t'(4 * beat)) ^ SRC_KEY))
							mismatch("mem_wdata", prev_wdata,
								(exp_rd + addr_t'(4 * beat)) ^ SRC_KEY);
						words = words + 1;
					end
					if (beat == n - 1) begin
						in_burst = 1'b0;
						if (phase == WRITE) begin
							exp_rd = exp_rd + addr_t'(4 * n); // Both sides move by the burst size
							exp_wr = exp_wr + addr_t'(4 * n);
							rem    = rem - n;
							phase  = READ;
						end else begin
							phase = WRITE;
						end
					end else begin
						beat = beat + 1;
					end
				end
			end else if (!mem_ceb) begin
				if (!active || rem <= 0) begin
					$display("Memory access at 0x%08h with no transfer pending", mem_addr);
					err_cnt  = err_cnt + 1;
					test_err = test_err + 1;
				end else begin
					n = next_burst_words();
					if (mem_web !== (phase == READ))
						mismatch("mem_web", data_t'(mem_web), data_t'(phase == READ));
					if (mem_addr !== ((phase == READ) ? exp_rd : exp_wr))
						mismatch("mem_addr", mem_addr, (phase == READ) ? exp_rd : exp_wr);
					if (mem_burst_len !== burst_len_t'(n - 1))
						mismatch("mem_burst_len", data_t'(mem_burst_len), data_t'(n - 1));
					if (mem_bweb !== ((phase == READ) ? 4'hf : 4'h0))
						mismatch("mem_bweb", data_t'(mem_bweb),
							(phase == READ) ? 32'hf : 32'h0);
					last_byte = mem_addr + addr_t'(4 * (int'(mem_burst_len) + 1)) - 32'd1;
					if (mem_addr[31:12] != last_byte[31:12]) begin
						$display("Burst at 0x%08h crosses a page boundary", mem_addr);
						test_err = test_err + 1;
						err_cnt  = err_cnt + 1;
					end
					in_burst = 1'b1;
					beat     = 0;
				end
			end
			prev_wdata = mem_wdata;
		end
	end

endmodule

// ==== verification/tb_dma.sv ====
`timescale 1ns/1ps
`include "dma_cfg.svh"

module tb_dma;
	import dma_pkg::*;

	logic       clk;
	logic       rst;
	logic       cfg_en;
	addr_t      cfg_addr;
	data_t      cfg_data;
	data_t      mem_rdata;
	logic       mem_rvalid;
	logic       mem_wvalid;
	addr_t      mem_addr;
	logic [3:0] mem_bweb;
	data_t      mem_wdata;
	burst_len_t mem_burst_len;
	logic       mem_ceb;
	logic       mem_web;
	logic       irq;
	integer     seed = 32'hcc852b32;
	int         tb_err = 0;
	logic       timed_out = 1'b0;

	dma_top u_dma_top (.*);

	dma_mem_model u_mem (.clk(clk), .rst(rst), .mem_ceb(mem_ceb), .mem_web(mem_web),
		.mem_addr(mem_addr), .mem_burst_len(mem_burst_len), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_wvalid(mem_wvalid));

	dma_checker u_chk (.clk(clk), .rst(rst), .mem_ceb(mem_ceb), .mem_web(mem_web),
		.mem_addr(mem_addr), .mem_bweb(mem_bweb), .mem_wdata(mem_wdata),
		.mem_burst_len(mem_burst_len), .mem_rvalid(mem_rvalid), .mem_wvalid(mem_wvalid));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic cfg_write(addr_t a, data_t d);
		@(posedge clk);
		cfg_en   <= 1'b1;
		cfg_addr <= a;
		cfg_data <= d;
		@(posedge clk);
		cfg_en <= 1'b0;
	endtask

	task automatic wait_irq(logic level, int limit, output logic ok);
		ok = 1'b0;
		for (int i = 0; i < limit; i++) begin
			@(negedge clk);
			if (irq === level) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	initial begin
		addr_t src;
		addr_t dst;
		int    len;
		logic  ok;
		rst      = 1'b1;
		cfg_en   = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (6) begin
			@(negedge clk);
			if (mem_ceb !== 1'b1 || mem_web !== 1'b1 || irq !== 1'b0) begin
				$display("[FAIL] idle outputs mem_ceb=0x%0h mem_web=0x%0h irq=0x%0h",
					mem_ceb, mem_web, irq);
				tb_err = tb_err + 1;
			end
		end
		$display("Reset test: %0d errors", tb_err);
		for (int t = 0; t < 16 && !timed_out; t++) begin
			if (t % 4 != 1) begin // Otherwise rerun the last copy on the kept registers
				src = 32'h00010000 + (addr_t'($random(seed)) & 32'h0000fffc);
				dst = 32'h00400000 + (addr_t'($random(seed)) & 32'h0000fffc);
				len = 1 + int'($unsigned($random(seed)) % 40);
				if (t % 4 == 0) len = 1 + int'($unsigned($random(seed)) % 3);
				if (t % 4 == 2) // Source a few words short of its page end
					src = (src & 32'hfffff000) + 32'h1000
						- addr_t'(4 * (1 + int'($unsigned($random(seed)) % 6)));
				if (t % 4 == 3)
					dst = (dst & 32'hfffff000) + 32'h1000
						- addr_t'(4 * (1 + int'($unsigned($random(seed)) % 6)));
				cfg_write(`DMA_REG_SRC, src);
				cfg_write(`DMA_REG_DST, dst);
				cfg_write(`DMA_REG_LEN, data_t'(len));
			end
			u_chk.start_test(src, dst, len);
			cfg_write(`DMA_REG_EN, 32'd1);
			cfg_write(`DMA_REG_SRC, 32'h7fff0000); // Must not disturb the running copy
			cfg_write(`DMA_REG_DST, 32'h7ffe0000);
			wait_irq(1'b1, 3000, ok);
			if (!ok) begin
				$display("Timeout: irq never rose in test %0d", t);
				timed_out = 1'b1;
			end else begin
				repeat (3) begin
					@(negedge clk);
					if (irq !== 1'b1) begin
						$display("irq dropped before enable was cleared in test %0d", t);
						tb_err = tb_err + 1;
					end
				end
				cfg_write(`DMA_REG_EN, 32'd0);
				wait_irq(1'b0, 5, ok);
				if (!ok) begin
					$display("irq stayed high after enable was cleared in test %0d", t);
					tb_err = tb_err + 1;
				end
				for (int i = 0; i < len; i++) begin
					u_chk.check_word(i, u_mem.take_word(dst + addr_t'(4 * i)));
				end
				u_chk.end_test(t);
			end
		end
		$display("Tests: %0d passed, %0d failed, %0d checker errors, %0d other errors",
			u_chk.pass_cnt, u_chk.fail_cnt, u_chk.err_cnt, tb_err);
		if (tb_err == 0 && u_chk.err_cnt == 0 && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== dma_top.f ====
+incdir+common
common/dma_pkg.sv
dma/dma_regs.sv
dma/dma_burst_planner.sv
dma/dma_burst_buffer.sv
dma/dma_engine.sv
hdl/dma_top.sv
verification/dma_mem_model.sv
verification/dma_checker.sv
verification/tb_dma.sv

// ==== Makefile ====
sim:
	verilator --binary --timing -f dma_top.f --top-module tb_dma -o tb_dma_sim
	./obj_dir/tb_dma_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
